/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_id_stage
FILE_LIST = rv_decode.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* branch_unit.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module branch_unit
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  inst_u            inst_i,
	input  logic [`XLEN-1:0] pc_i,
	input  logic [`XLEN-1:0] op1_i,
	input  logic [`XLEN-1:0] op2_i,
	input  logic [`XLEN-1:0] imm_i,
	input  logic             is_jal_i,
	input  logic             is_jalr_i,
	input  logic             is_branch_i,
	input  logic             fire_i,
	output branch_t          branch_o,
	output logic [`XLEN-1:0] link_addr_o
);

	logic             eq;
	logic             lt_s;
	logic             lt_u;
	logic             cond;
	logic [`XLEN-1:0] jalr_sum;

	assign eq   = op1_i == op2_i;
	assign lt_s = $signed(op1_i) < $signed(op2_i);
	assign lt_u = op1_i < op2_i;

	always_comb begin
		case (inst_i.b.funct3)
			F3_BEQ:  cond = eq;
			F3_BNE:  cond = !eq;
			F3_BLT:  cond = lt_s;
			F3_BGE:  cond = !lt_s;
			F3_BLTU: cond = lt_u;
			F3_BGEU: cond = !lt_u;
			default: cond = 1'b0;
		endcase
	end

	assign jalr_sum = op1_i + imm_i; // imm is the I immediate for jalr

	assign branch_o.taken  = fire_i && (is_jal_i || is_jalr_i || (is_branch_i && cond));
	assign branch_o.target = is_jalr_i ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_i + imm_i;

	// only jumps write a return address
	assign link_addr_o = (is_jal_i || is_jalr_i) ? pc_i + 'd4 : '0;

endmodule

/* id_stage.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module id_stage
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic             clk,
	input  logic             rst_i,
	input  logic             inst_valid_i,
	input  logic [`XLEN-1:0] pc_i,
	input  inst_u            inst_i,
	input  logic [`XLEN-1:0] rf_data1_i,
	input  logic [`XLEN-1:0] rf_data2_i,
	input  fwd_t             ex_fwd_i,
	input  fwd_t             mem_fwd_i,
	input  logic             stall_i,
	output rf_read_t         rf_read_o,
	output branch_t          branch_o,
	output id_ex_t           id_ex_o
);

	alusel_e          alusel;
	imm_sel_e         imm_sel;
	logic             wreg;
	logic             is_jal;
	logic             is_jalr;
	logic             is_branch;
	logic             legal;
	logic             fire;
	logic             keep_f7;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic [`XLEN-1:0] link_addr;
	id_ex_t           id_ex_next;

	assign fire = inst_valid_i && !stall_i;

	inst_decoder u_dec (
		.inst_i      (inst_i),
		.rf_read_o   (rf_read_o),
		.alusel_o    (alusel),
		.wreg_o      (wreg),
		.imm_sel_o   (imm_sel),
		.is_jal_o    (is_jal),
		.is_jalr_o   (is_jalr),
		.is_branch_o (is_branch),
		.legal_o     (legal)
	);

	imm_gen u_imm (
		.inst_i    (inst_i),
		.pc_i      (pc_i),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	operand_forward u_fwd1 (
		.rd_en_i   (rf_read_o.re1),
		.addr_i    (rf_read_o.addr1),
		.rf_data_i (rf_data1_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (imm),
		.operand_o (op1)
	);

	operand_forward u_fwd2 (
		.rd_en_i   (rf_read_o.re2),
		.addr_i    (rf_read_o.addr2),
		.rf_data_i (rf_data2_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (imm),
		.operand_o (op2)
	);

	branch_unit u_br (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.op1_i       (op1),
		.op2_i       (op2),
		.imm_i       (imm),
		.is_jal_i    (is_jal),
		.is_jalr_i   (is_jalr),
		.is_branch_i (is_branch),
		.fire_i      (fire),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	// funct7 only means something for shifts and add/sub
	assign keep_f7 = alusel == ALU_SHI ||
		(legal && inst_i.r.opcode == OPC_OP && inst_i.r.funct3 == F3_ADD_SUB);

	always_comb begin
		id_ex_next.valid     = inst_valid_i;
		id_ex_next.illegal   = inst_valid_i && !legal;
		id_ex_next.alusel    = alusel;
		id_ex_next.opcode    = inst_i.r.opcode;
		id_ex_next.funct3    = (imm_sel == IMM_U || imm_sel == IMM_J) ? '0 : inst_i.r.funct3;
		id_ex_next.funct7    = keep_f7 ? inst_i.r.funct7 : '0;
		id_ex_next.reg1      = op1;
		id_ex_next.reg2      = op2;
		id_ex_next.wd        = inst_i.r.rd;
		id_ex_next.wreg      = wreg && legal; // no writeback from a bad encoding
		id_ex_next.link_addr = link_addr;
		id_ex_next.inst      = inst_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			id_ex_o <= '0;
		else if (!stall_i)
			id_ex_o <= id_ex_next; // hold while stalled
	end

endmodule

/* imm_gen.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module imm_gen
	import rv_isa_pkg::*;
(
	input  inst_u            inst_i,
	input  logic [`XLEN-1:0] pc_i,
	input  imm_sel_e         imm_sel_i,
	output logic [`XLEN-1:0] imm_o
);

	logic [`XLEN-1:0] u_imm;

	assign u_imm = {inst_i.u.imm_31_12, 12'b0};

	always_comb begin
		case (imm_sel_i)
			IMM_I: imm_o = {{(`XLEN-12){inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
			IMM_SHAMT: imm_o = {{(`XLEN-5){1'b0}}, inst_i.r.rs2}; // shamt sits in rs2
			IMM_S: imm_o = {{(`XLEN-12){inst_i.s.imm_11_5[6]}},
					inst_i.s.imm_11_5, inst_i.s.imm_4_0};
			IMM_B: imm_o = {{(`XLEN-12){inst_i.b.imm_12}}, inst_i.b.imm_11,
					inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
			IMM_U: begin
				// auipc operand already holds pc + upper imm
				if (inst_i.u.opcode == OPC_AUIPC)
					imm_o = u_imm + pc_i;
				else
					imm_o = u_imm;
			end
			IMM_J: imm_o = {{(`XLEN-20){inst_i.j.imm_20}}, inst_i.j.imm_19_12,
					inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
			default: imm_o = '0;
		endcase
	end

endmodule

/* inst_decoder.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module inst_decoder
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  inst_u    inst_i,
	output rf_read_t rf_read_o,
	output alusel_e  alusel_o,
	output logic     wreg_o,
	output imm_sel_e imm_sel_o,
	output logic     is_jal_o,
	output logic     is_jalr_o,
	output logic     is_branch_o,
	output logic     legal_o
);

	logic re1;
	logic re2;
	logic imm_ok; // OP-IMM funct7 check
	logic op_ok;  // OP funct7 check

	function automatic alusel_e alu_class(input logic [`F3_W-1:0] f3);
		case (f3)
			F3_ADD_SUB, F3_SLT, F3_SLTU: alu_class = ALU_ARI;
			F3_XOR, F3_OR, F3_AND:       alu_class = ALU_LOG;
			default:                     alu_class = ALU_SHI;
		endcase
	endfunction

	always_comb begin
		case (inst_i.r.funct3)
			F3_SLL:     imm_ok = inst_i.r.funct7 == F7_SRL;
			F3_SRL_SRA: imm_ok = inst_i.r.funct7 == F7_SRL || inst_i.r.funct7 == F7_SRA;
			default:    imm_ok = 1'b1; // funct7 is immediate bits here
		endcase
		case (inst_i.r.funct3)
			F3_ADD_SUB: op_ok = inst_i.r.funct7 == F7_ADD || inst_i.r.funct7 == F7_SUB;
			F3_SRL_SRA: op_ok = inst_i.r.funct7 == F7_SRL || inst_i.r.funct7 == F7_SRA;
			default:    op_ok = inst_i.r.funct7 == F7_ADD;
		endcase
	end

	always_comb begin
		re1         = 1'b0;
		re2         = 1'b0;
		alusel_o    = ALU_NOP;
		wreg_o      = 1'b0;
		imm_sel_o   = IMM_NONE;
		is_jal_o    = 1'b0;
		is_jalr_o   = 1'b0;
		is_branch_o = 1'b0;
		legal_o     = 1'b0;
		case (inst_i.r.opcode)
			OPC_LUI, OPC_AUIPC: begin
				alusel_o  = ALU_LOG;
				wreg_o    = 1'b1;
				imm_sel_o = IMM_U;
				legal_o   = 1'b1;
			end
			OPC_JAL: begin
				alusel_o  = ALU_JAB;
				wreg_o    = 1'b1;
				imm_sel_o = IMM_J;
				is_jal_o  = 1'b1;
				legal_o   = 1'b1;
			end
			OPC_JALR: if (inst_i.i.funct3 == F3_JALR) begin
				re1       = 1'b1;
				alusel_o  = ALU_JAB;
				wreg_o    = 1'b1;
				imm_sel_o = IMM_I;
				is_jalr_o = 1'b1;
				legal_o   = 1'b1;
			end
			OPC_BRANCH: case (inst_i.b.funct3)
				F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
					re1         = 1'b1;
					re2         = 1'b1;
					alusel_o    = ALU_JAB;
					imm_sel_o   = IMM_B;
					is_branch_o = 1'b1;
					legal_o     = 1'b1;
				end
				default: ; // funct3 2 and 3 are reserved
			endcase
			OPC_LOAD: case (inst_i.i.funct3)
				F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: begin
					re1       = 1'b1;
					alusel_o  = ALU_LAS;
					wreg_o    = 1'b1;
					imm_sel_o = IMM_I;
					legal_o   = 1'b1;
				end
				default: ;
			endcase
			OPC_STORE: case (inst_i.s.funct3)
				F3_SB, F3_SH, F3_SW: begin
					re1       = 1'b1;
					re2       = 1'b1;
					alusel_o  = ALU_LAS;
					imm_sel_o = IMM_S;
					legal_o   = 1'b1;
				end
				default: ;
			endcase
			OPC_OP_IMM: if (imm_ok) begin
				re1       = 1'b1;
				alusel_o  = alu_class(inst_i.i.funct3);
				wreg_o    = 1'b1;
				imm_sel_o = alu_class(inst_i.i.funct3) == ALU_SHI ? IMM_SHAMT : IMM_I;
				legal_o   = 1'b1;
			end
			OPC_OP: if (op_ok) begin
				re1      = 1'b1;
				re2      = 1'b1;
				alusel_o = alu_class(inst_i.r.funct3);
				wreg_o   = 1'b1;
				legal_o  = 1'b1;
			end
			default: ;
		endcase
	end

	// disabled ports point at x0
	assign rf_read_o.re1   = re1;
	assign rf_read_o.re2   = re2;
	assign rf_read_o.addr1 = re1 ? inst_i.r.rs1 : REG_ZERO;
	assign rf_read_o.addr2 = re2 ? inst_i.r.rs2 : REG_ZERO;

endmodule

/* operand_forward.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module operand_forward
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic               rd_en_i,
	input  logic [`REG_AW-1:0] addr_i,
	input  logic [`XLEN-1:0]   rf_data_i,
	input  fwd_t               ex_fwd_i,
	input  fwd_t               mem_fwd_i,
	input  logic [`XLEN-1:0]   imm_i,
	output logic [`XLEN-1:0]   operand_o
);

	logic ex_hit;
	logic mem_hit;

	// x0 never matches a later stage
	assign ex_hit  = ex_fwd_i.we && addr_i != REG_ZERO && ex_fwd_i.addr == addr_i;
	assign mem_hit = mem_fwd_i.we && addr_i != REG_ZERO && mem_fwd_i.addr == addr_i;

	always_comb begin
		if (!rd_en_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_fwd_i.data; // youngest result first
		else if (mem_hit)
			operand_o = mem_fwd_i.data;
		else
			operand_o = rf_data_i;
	end

endmodule

/* rv_decode.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
inst_decoder.sv
imm_gen.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

/* rv_isa_pkg.sv */
`include "rv_params.svh"

package rv_isa_pkg;

	// major opcodes handled by the decode stage
	typedef enum logic [`OPC_W-1:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	localparam logic [`F3_W-1:0] F3_JALR    = 3'b000;

	localparam logic [`F3_W-1:0] F3_BEQ     = 3'b000;
	localparam logic [`F3_W-1:0] F3_BNE     = 3'b001;
	localparam logic [`F3_W-1:0] F3_BLT     = 3'b100;
	localparam logic [`F3_W-1:0] F3_BGE     = 3'b101;
	localparam logic [`F3_W-1:0] F3_BLTU    = 3'b110;
	localparam logic [`F3_W-1:0] F3_BGEU    = 3'b111;

	localparam logic [`F3_W-1:0] F3_LB      = 3'b000;
	localparam logic [`F3_W-1:0] F3_LH      = 3'b001;
	localparam logic [`F3_W-1:0] F3_LW      = 3'b010;
	localparam logic [`F3_W-1:0] F3_LBU     = 3'b100;
	localparam logic [`F3_W-1:0] F3_LHU     = 3'b101;

	localparam logic [`F3_W-1:0] F3_SB      = 3'b000;
	localparam logic [`F3_W-1:0] F3_SH      = 3'b001;
	localparam logic [`F3_W-1:0] F3_SW      = 3'b010;

	// shared by OP and OP-IMM
	localparam logic [`F3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [`F3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [`F3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [`F3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [`F3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [`F3_W-1:0] F3_SRL_SRA = 3'b101;
	localparam logic [`F3_W-1:0] F3_OR      = 3'b110;
	localparam logic [`F3_W-1:0] F3_AND     = 3'b111;

	localparam logic [`F7_W-1:0] F7_ADD     = 7'b0000000;
	localparam logic [`F7_W-1:0] F7_SUB     = 7'b0100000;
	localparam logic [`F7_W-1:0] F7_SRL     = 7'b0000000;
	localparam logic [`F7_W-1:0] F7_SRA     = 7'b0100000;

	localparam logic [`REG_AW-1:0] REG_ZERO = '0; // x0 reads as zero

	typedef struct packed {
		logic [`F7_W-1:0]   funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [`F3_W-1:0]   funct3;
		logic [`REG_AW-1:0] rd;
		logic [`OPC_W-1:0]  opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]        imm_11_0;
		logic [`REG_AW-1:0] rs1;
		logic [`F3_W-1:0]   funct3;
		logic [`REG_AW-1:0] rd;
		logic [`OPC_W-1:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]         imm_11_5;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [`F3_W-1:0]   funct3;
		logic [4:0]         imm_4_0;
		logic [`OPC_W-1:0]  opcode;
	} s_fmt_t;

	typedef struct packed {
		logic               imm_12;
		logic [5:0]         imm_10_5;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [`F3_W-1:0]   funct3;
		logic [3:0]         imm_4_1;
		logic               imm_11;
		logic [`OPC_W-1:0]  opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]        imm_31_12;
		logic [`REG_AW-1:0] rd;
		logic [`OPC_W-1:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic               imm_20;
		logic [9:0]         imm_10_1;
		logic               imm_11;
		logic [7:0]         imm_19_12;
		logic [`REG_AW-1:0] rd;
		logic [`OPC_W-1:0]  opcode;
	} j_fmt_t;

	// one fetched word, seen through every base format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef enum logic [2:0] {
		IMM_NONE  = 3'd0,
		IMM_I     = 3'd1,
		IMM_SHAMT = 3'd2,
		IMM_S     = 3'd3,
		IMM_B     = 3'd4,
		IMM_U     = 3'd5,
		IMM_J     = 3'd6
	} imm_sel_e;

endpackage

/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine word, also the pc width
`define XLEN   32

// x0..x31
`define REG_AW 5

// instruction field widths
`define OPC_W  7
`define F3_W   3
`define F7_W   7

`endif

/* rv_pipe_pkg.sv */
`include "rv_params.svh"

package rv_pipe_pkg;

	typedef enum logic [2:0] {
		ALU_NOP = 3'd0,
		ALU_LOG = 3'd1, // and/or/xor, lui, auipc
		ALU_ARI = 3'd2, // add/sub, slt
		ALU_SHI = 3'd3,
		ALU_JAB = 3'd4, // jumps and branches
		ALU_LAS = 3'd5  // loads and stores
	} alusel_e;

	// read request to the register file
	typedef struct packed {
		logic               re1;
		logic               re2;
		logic [`REG_AW-1:0] addr1;
		logic [`REG_AW-1:0] addr2;
	} rf_read_t;

	// result coming back from a later stage
	typedef struct packed {
		logic               we;
		logic [`REG_AW-1:0] addr;
		logic [`XLEN-1:0]   data;
	} fwd_t;

	typedef struct packed {
		logic               valid;
		logic               illegal;
		alusel_e            alusel;
		logic [`OPC_W-1:0]  opcode;
		logic [`F3_W-1:0]   funct3;
		logic [`F7_W-1:0]   funct7;
		logic [`XLEN-1:0]   reg1;
		logic [`XLEN-1:0]   reg2;
		logic [`REG_AW-1:0] wd;
		logic               wreg;
		logic [`XLEN-1:0]   link_addr;
		logic [`XLEN-1:0]   inst;
	} id_ex_t;

	// redirect toward the pc
	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} branch_t;

endpackage

/* tb_id_stage.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module tb_id_stage
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
();

	typedef struct packed {
		rf_read_t rd;
		branch_t  br;
		logic     tgt_chk; // target only matters for jumps and branches
		id_ex_t   pkt;
	} expect_t;

	logic             clk;
	logic             rst_i;
	logic             inst_valid_i;
	logic [`XLEN-1:0] pc_i;
	inst_u            inst_i;
	logic [`XLEN-1:0] rf_data1_i;
	logic [`XLEN-1:0] rf_data2_i;
	fwd_t             ex_fwd_i;
	fwd_t             mem_fwd_i;
	logic             stall_i;
	rf_read_t         rf_read_o;
	branch_t          branch_o;
	id_ex_t           id_ex_o;

	logic [`XLEN-1:0] rf_mem [32];
	expect_t          want;
	id_ex_t           want_q;
	int               err_cnt = 0;
	int               timeout_cnt = 0;
	int               tests_run = 0;
	int               tests_failed = 0;
	int               mark = 0;

	id_stage id_stage_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.rf_data1_i   (rf_data1_i),
		.rf_data2_i   (rf_data2_i),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.stall_i      (stall_i),
		.rf_read_o    (rf_read_o),
		.branch_o     (branch_o),
		.id_ex_o      (id_ex_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// register file answers in the same cycle
	assign rf_data1_i = (rf_read_o.addr1 == 5'd0) ? 32'd0 : rf_mem[rf_read_o.addr1];
	assign rf_data2_i = (rf_read_o.addr2 == 5'd0) ? 32'd0 : rf_mem[rf_read_o.addr2];

	function automatic alusel_e op_class(input logic [2:0] f3);
		if (f3 == 3'd1 || f3 == 3'd5)
			return ALU_SHI;
		if (f3 == 3'd4 || f3 >= 3'd6)
			return ALU_LOG;
		return ALU_ARI;
	endfunction

	function automatic logic [31:0] pick_operand(input logic en, input logic [4:0] a,
		input logic [31:0] rf_val, input fwd_t ex, input fwd_t mem, input logic [31:0] imm);
		if (!en)
			return imm;
		if (a == 5'd0)
			return 32'd0;
		if (ex.we && ex.addr == a)
			return ex.data; // youngest wins
		if (mem.we && mem.addr == a)
			return mem.data;
		return rf_val;
	endfunction

	function automatic expect_t predict(input logic [31:0] w, input logic [31:0] pc,
		input logic valid, input logic stall, input fwd_t ex, input fwd_t mem,
		input logic [31:0] rs1_val, input logic [31:0] rs2_val);
		expect_t     e;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm;
		logic [31:0] op1;
		logic [31:0] op2;
		logic        legal;
		logic        re1;
		logic        re2;
		logic        wr;
		logic        jump;
		logic        is_br;
		logic        cond;
		alusel_e     cls;
		opc   = w[6:0];
		f3    = w[14:12];
		f7    = w[31:25];
		legal = 1'b1;
		re1   = 1'b0;
		re2   = 1'b0;
		wr    = 1'b0;
		cls   = ALU_NOP;
		imm   = 32'd0;
		e     = '0;
		case (opc)
			OPC_LUI, OPC_AUIPC: begin
				wr  = 1'b1;
				cls = ALU_LOG;
				imm = {w[31:12], 12'b0};
				if (opc == OPC_AUIPC)
					imm = imm + pc;
			end
			OPC_JAL: begin
				wr  = 1'b1;
				cls = ALU_JAB;
				imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			OPC_JALR: begin
				legal = f3 == 3'd0;
				re1   = 1'b1;
				wr    = 1'b1;
				cls   = ALU_JAB;
				imm   = {{20{w[31]}}, w[31:20]};
			end
			OPC_BRANCH: begin
				legal = f3 != 3'd2 && f3 != 3'd3;
				re1   = 1'b1;
				re2   = 1'b1;
				cls   = ALU_JAB;
				imm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			OPC_LOAD: begin
				legal = f3 != 3'd3 && f3 < 3'd6;
				re1   = 1'b1;
				wr    = 1'b1;
				cls   = ALU_LAS;
				imm   = {{20{w[31]}}, w[31:20]};
			end
			OPC_STORE: begin
				legal = f3 < 3'd3;
				re1   = 1'b1;
				re2   = 1'b1;
				cls   = ALU_LAS;
				imm   = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			OPC_OP_IMM: begin
				legal = !(f3 == 3'd1 && f7 != 7'h00) &&
					!(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
				re1   = 1'b1;
				wr    = 1'b1;
				cls   = op_class(f3);
				imm   = (cls == ALU_SHI) ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
			end
			OPC_OP: begin
				legal = (f3 == 3'd0 || f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : f7 == 7'h00;
				re1   = 1'b1;
				re2   = 1'b1;
				wr    = 1'b1;
				cls   = op_class(f3);
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			re1 = 1'b0;
			re2 = 1'b0;
			wr  = 1'b0;
			cls = ALU_NOP;
			imm = 32'd0;
		end
		e.rd.re1   = re1;
		e.rd.re2   = re2;
		e.rd.addr1 = re1 ? w[19:15] : 5'd0;
		e.rd.addr2 = re2 ? w[24:20] : 5'd0;
		op1 = pick_operand(re1, e.rd.addr1, rs1_val, ex, mem, imm);
		op2 = pick_operand(re2, e.rd.addr2, rs2_val, ex, mem, imm);
		case (f3)
			3'd0:    cond = op1 == op2;
			3'd1:    cond = op1 != op2;
			3'd4:    cond = $signed(op1) < $signed(op2);
			3'd5:    cond = $signed(op1) >= $signed(op2);
			3'd6:    cond = op1 < op2;
			default: cond = op1 >= op2;
		endcase
		jump  = legal && (opc == OPC_JAL || opc == OPC_JALR);
		is_br = legal && opc == OPC_BRANCH;
		e.tgt_chk   = jump || is_br;
		e.br.taken  = valid && !stall && (jump || (is_br && cond));
		e.br.target = (legal && opc == OPC_JALR) ? ((op1 + imm) & ~32'd1) : pc + imm;
		e.pkt.valid     = valid;
		e.pkt.illegal   = valid && !legal;
		e.pkt.alusel    = cls;
		e.pkt.opcode    = opc;
		e.pkt.funct3    = (legal && (opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_JAL)) ?
			3'd0 : f3;
		e.pkt.funct7    = (cls == ALU_SHI || (legal && opc == OPC_OP && f3 == 3'd0)) ? f7 : 7'd0;
		e.pkt.reg1      = op1;
		e.pkt.reg2      = op2;
		e.pkt.wd        = w[11:7];
		e.pkt.wreg      = wr;
		e.pkt.link_addr = jump ? pc + 32'd4 : 32'd0;
		e.pkt.inst      = w;
		return e;
	endfunction

	always_comb begin
		want = predict(inst_i, pc_i, inst_valid_i, stall_i, ex_fwd_i, mem_fwd_i,
			rf_mem[inst_i.r.rs1], rf_mem[inst_i.r.rs2]);
	end

	// expected packet one cycle behind
	always_ff @(posedge clk) begin
		if (rst_i)
			want_q <= '0;
		else if (!stall_i)
			want_q <= want.pkt;
	end

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("[FAIL] t=%0t %s", $time, msg);
	endtask

	rd_chk: assert property (@(posedge clk) disable iff (rst_i) rf_read_o == want.rd)
		else flag_error("register read request differs from expected");
	taken_chk: assert property (@(posedge clk) disable iff (rst_i)
		branch_o.taken == want.br.taken)
		else flag_error("branch taken flag differs from expected");
	target_chk: assert property (@(posedge clk) disable iff (rst_i)
		want.tgt_chk |-> branch_o.target == want.br.target)
		else flag_error("redirect target differs from expected");
	pkt_chk: assert property (@(posedge clk) disable iff (rst_i) id_ex_o == want_q)
		else flag_error("id_ex packet differs from expected");
	reset_chk: assert property (@(posedge clk) rst_i |=> id_ex_o == '0)
		else flag_error("packet not cleared by reset");
	stall_hold_chk: assert property (@(posedge clk) (stall_i && !rst_i) |=> $stable(id_ex_o))
		else flag_error("packet changed while stalled");
	stall_taken_chk: assert property (@(posedge clk) disable iff (rst_i)
		stall_i |-> !branch_o.taken)
		else flag_error("redirect taken while stalled");
	illegal_chk: assert property (@(posedge clk) disable iff (rst_i)
		id_ex_o.illegal |-> !id_ex_o.wreg)
		else flag_error("illegal packet has write enable set");

	task automatic present(input logic [31:0] w, input logic stall);
		@(posedge clk);
		inst_valid_i <= 1'b1;
		inst_i       <= w;
		pc_i         <= $urandom() & 32'hffff_fffc;
		stall_i      <= stall;
	endtask

	task automatic go_idle();
		@(posedge clk);
		inst_valid_i <= 1'b0;
		stall_i      <= 1'b0;
		ex_fwd_i.we  <= 1'b0;
		mem_fwd_i.we <= 1'b0;
	endtask

	task automatic wait_valid_level(input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (id_ex_o.valid !== level && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (id_ex_o.valid !== level) begin
			timeout_cnt++;
			$display("timed out after %0d cycles waiting for %s", n, what);
		end
	endtask

	task automatic close_test(input string name);
		go_idle();
		wait_valid_level(1'b0, "the stage to drain");
		tests_run++;
		if (err_cnt + timeout_cnt == mark) begin
			$display("test %-14s ok", name);
		end else begin
			tests_failed++;
			$display("test %-14s FAILED with %0d errors", name, err_cnt + timeout_cnt - mark);
		end
		mark = err_cnt + timeout_cnt;
	endtask

	task automatic alu_mix();
		logic [31:0] w;
		logic [2:0]  f3;
		for (int k = 0; k < 80; k++) begin
			w  = $urandom();
			f3 = w[14:12];
			case ($urandom_range(3, 0))
				0: begin
					w[6:0]   = OPC_OP;
					w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
				end
				1: begin
					w[6:0] = OPC_OP_IMM;
					if (f3 == 3'd1 || f3 == 3'd5)
						w[31:25] = (f3 == 3'd5 && w[30]) ? 7'h20 : 7'h00;
				end
				2: w[6:0] = OPC_LUI;
				default: w[6:0] = OPC_AUIPC;
			endcase
			present(w, 1'b0);
		end
		close_test("alu_mix");
	endtask

	task automatic forward_mix();
		logic [31:0] w;
		fwd_t        ex_f;
		fwd_t        mem_f;
		for (int k = 0; k < 60; k++) begin
			w        = $urandom();
			w[6:0]   = OPC_OP;
			w[14:12] = 3'd0;
			w[31:25] = 7'h00;
			w[19:15] = 5'($urandom_range(3, 0)); // small set so stages collide
			w[24:20] = 5'($urandom_range(3, 0));
			ex_f.we    = 1'($urandom_range(1, 0));
			ex_f.addr  = 5'($urandom_range(3, 0));
			ex_f.data  = $urandom();
			mem_f.we   = 1'($urandom_range(1, 0));
			mem_f.addr = 5'($urandom_range(3, 0));
			mem_f.data = $urandom();
			present(w, 1'b0);
			ex_fwd_i  <= ex_f;
			mem_fwd_i <= mem_f;
		end
		close_test("forward_mix");
	endtask

	task automatic branch_sweep();
		logic [31:0] w;
		logic [2:0]  f3;
		for (int k = 0; k < 80; k++) begin
			w      = $urandom();
			w[6:0] = OPC_BRANCH;
			f3     = 3'($urandom_range(5, 0));
			if (f3 >= 3'd2)
				f3 = f3 + 3'd2; // skip reserved 2 and 3
			w[14:12] = f3;
			if (!k[0]) begin
				w[19:15] = 5'($urandom_range(7, 0)); // edge values live in x1..x6
				w[24:20] = 5'($urandom_range(7, 0));
			end
			present(w, 1'b0);
		end
		close_test("branch_sweep");
	endtask

	task automatic jump_and_mem();
		logic [31:0] w;
		logic [2:0]  f3;
		for (int k = 0; k < 60; k++) begin
			w = $urandom();
			case (k % 4)
				0: w[6:0] = OPC_JAL;
				1: begin
					w[6:0]   = OPC_JALR;
					w[14:12] = 3'd0;
				end
				2: begin
					f3 = 3'($urandom_range(4, 0));
					if (f3 >= 3'd3)
						f3 = f3 + 3'd1;
					w[6:0]   = OPC_LOAD;
					w[14:12] = f3;
				end
				default: begin
					w[6:0]   = OPC_STORE;
					w[14:12] = 3'($urandom_range(2, 0));
				end
			endcase
			present(w, 1'b0);
		end
		close_test("jump_and_mem");
	endtask

	task automatic stall_and_reset();
		logic [31:0] w;
		w        = $urandom();
		w[6:0]   = OPC_OP_IMM;
		w[14:12] = 3'd0;
		present(w, 1'b0);
		w      = $urandom();
		w[6:0] = OPC_JAL; // would redirect if not stalled
		for (int k = 0; k < 4; k++)
			present(w, 1'b1);
		present(w, 1'b0);
		go_idle();
		@(posedge clk);
		rst_i <= 1'b1;
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		wait_valid_level(1'b0, "reset to clear the packet");
		present(w, 1'b0);
		close_test("stall_and_reset");
	endtask

	task automatic illegal_words();
		logic [31:0] w;
		for (int k = 0; k < 40; k++) begin
			w = $urandom();
			case (k % 5)
				0: begin
					w[6:0]   = OPC_BRANCH;
					w[14:12] = {2'b01, k[1]}; // funct3 2 or 3
				end
				1: w[6:0] = 7'b0001111; // misc-mem
				2: w[6:0] = 7'b1111111;
				3: begin
					w[6:0]   = OPC_OP;
					w[14:12] = 3'd7;
					w[31:25] = 7'h20;
				end
				default: begin
					w[6:0]   = OPC_LOAD;
					w[14:12] = 3'd3;
				end
			endcase
			present(w, 1'b0);
		end
		close_test("illegal_words");
	endtask

	initial begin
		void'($urandom(32'h5d62));
		rst_i        = 1'b1;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		stall_i      = 1'b0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		rf_mem[0]    = 32'd0;
		for (int i = 1; i < 32; i++)
			rf_mem[i] = $urandom();
		rf_mem[1] = 32'h0000_0000;
		rf_mem[2] = 32'h7fff_ffff;
		rf_mem[3] = 32'h8000_0000;
		rf_mem[4] = 32'hffff_ffff;
		rf_mem[5] = 32'h0000_0001;
		rf_mem[6] = 32'h8000_0000; // equal to x3
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		wait_valid_level(1'b0, "reset to finish");
		mark = err_cnt + timeout_cnt;
		alu_mix();
		forward_mix();
		branch_sweep();
		jump_and_mem();
		stall_and_reset();
		illegal_words();
		$display("tests run %0d, failed %0d, check errors %0d, timeouts %0d",
			tests_run, tests_failed, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
